// ==== mm_pkg.sv ====
//********************
// mm_pkg
// sizes, AXI field codes, data types and FSM
// encodings shared by the matrix-multiply accelerator
//********************
package mm_pkg;

    // matrix and buffer geometry
    localparam int MAT_N  = 4;
    localparam int DATA_W = 32;
    localparam int ROW_W  = 128;
    localparam int BUF_AW = 2;
    localparam int BEATS  = 16;
    localparam int ADDR_W = 32;

    // one 16-beat INCR burst of 4-byte words per matrix
    localparam logic [7:0] AXI_LEN  = 8'd15;
    localparam logic [2:0] AXI_SIZE = 3'd2;
    localparam logic [1:0] AXI_INCR = 2'd1;
    localparam logic [3:0] ID_A     = 4'd0;
    localparam logic [3:0] ID_B     = 4'd1;

    typedef logic [DATA_W-1:0] word_t;
    // column 0 sits in the top 32 bits
    typedef logic [ROW_W-1:0]  row_t;
    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic [2:0] {
        DMA_IDLE,
        DMA_ADDR_A,
        DMA_ADDR_B,
        DMA_LOAD,
        DMA_RUN_MM,
        DMA_ADDR_C,
        DMA_WRITE_C,
        DMA_WAIT_B
    } dma_state_e;

    typedef enum logic [1:0] {
        MM_IDLE,
        MM_FETCH,
        MM_MAC,
        MM_FINISH
    } mm_state_e;

endpackage

// ==== mat_buffer.sv ====
`timescale 1ns/1ps
//********************
// mat_buffer
// four-row RAM, one write port, registered read
//********************
module mat_buffer import mm_pkg::*; (
    input  logic              clk,
    input  logic              we_i,
    input  logic [BUF_AW-1:0] waddr_i,
    input  row_t              wdata_i,
    input  logic [BUF_AW-1:0] raddr_i,
    output row_t              rdata_o
);

    row_t mem [0:(1<<BUF_AW)-1];

    // write side
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// ==== dma_engine.sv ====
`timescale 1ns/1ps
//********************
// dma_engine
// loads A and B into the row buffers over AXI reads,
// starts the multiply, then writes C back in one burst
//********************
module dma_engine import mm_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    // run configuration
    input  addr_t               mat_a_addr_i,
    input  addr_t               mat_b_addr_i,
    input  addr_t               mat_c_addr_i,
    input  logic                start_i,
    output logic                done_o,
    // AR channel
    output logic                arvalid_o,
    output logic [3:0]          arid_o,
    output addr_t               araddr_o,
    output logic [7:0]          arlen_o,
    output logic [2:0]          arsize_o,
    output logic [1:0]          arburst_o,
    input  logic                arready_i,
    // R channel
    input  logic                rvalid_i,
    input  logic [3:0]          rid_i,
    input  word_t               rdata_i,
    input  logic                rlast_i,
    output logic                rready_o,
    // AW channel
    output logic                awvalid_o,
    output addr_t               awaddr_o,
    output logic [7:0]          awlen_o,
    output logic [2:0]          awsize_o,
    output logic [1:0]          awburst_o,
    input  logic                awready_i,
    // W channel
    output logic                wvalid_o,
    output word_t               wdata_o,
    output logic [DATA_W/8-1:0] wstrb_o,
    output logic                wlast_o,
    input  logic                wready_i,
    // B channel, response code is not acted on
    input  logic                bvalid_i,
    input  logic [1:0]          bresp_i,
    output logic                bready_o,
    // row buffer write ports
    output logic                buf_a_we_o,
    output logic [BUF_AW-1:0]   buf_a_waddr_o,
    output row_t                buf_a_wdata_o,
    output logic                buf_b_we_o,
    output logic [BUF_AW-1:0]   buf_b_waddr_o,
    output row_t                buf_b_wdata_o,
    // multiply engine handshake
    output logic                mm_start_o,
    input  logic                mm_done_i,
    input  word_t [BEATS-1:0]   accum_i
);

    dma_state_e state_q, state_d;

    // run addresses, latched at start
    addr_t addr_a_q;
    addr_t addr_b_q;
    addr_t addr_c_q;

    // per-id read side, index 0 is A and 1 is B
    row_t              pack_q  [2];
    logic [1:0]        beat_q  [2];
    logic [BUF_AW-1:0] waddr_q [2];
    logic [1:0]        we_q;
    logic [1:0]        last_q;
    logic [1:0]        hit;

    logic [$clog2(BEATS)-1:0] wcnt_q;
    logic                     w_fire;
    logic                     run_start;
    logic                     load_done;

    assign hit[0]    = rvalid_i && rready_o && (rid_i == ID_A);
    assign hit[1]    = rvalid_i && rready_o && (rid_i == ID_B);
    assign w_fire    = wvalid_o && wready_i;
    assign run_start = (state_q == DMA_IDLE) && start_i;
    // both bursts seen their last beat, final row strobe is in flight
    assign load_done = (state_q == DMA_LOAD) && (&last_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            DMA_IDLE:    if (start_i)   state_d = DMA_ADDR_A;
            DMA_ADDR_A:  if (arready_i) state_d = DMA_ADDR_B;
            DMA_ADDR_B:  if (arready_i) state_d = DMA_LOAD;
            DMA_LOAD:    if (load_done) state_d = DMA_RUN_MM;
            DMA_RUN_MM:  if (mm_done_i) state_d = DMA_ADDR_C;
            DMA_ADDR_C:  if (awready_i) state_d = DMA_WRITE_C;
            DMA_WRITE_C: begin
                if (w_fire && (wcnt_q == BEATS - 1)) begin
                    state_d = DMA_WAIT_B;
                end
            end
            DMA_WAIT_B:  if (bvalid_i)  state_d = DMA_IDLE;
            default:     state_d = DMA_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= DMA_IDLE;
            we_q       <= '0;
            last_q     <= '0;
            wcnt_q     <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
            for (int b = 0; b < 2; b++) begin
                beat_q[b]  <= '0;
                waddr_q[b] <= '0;
            end
        end else begin
            state_q    <= state_d;
            mm_start_o <= load_done;
            done_o     <= (state_q == DMA_WAIT_B) && bvalid_i;
            if (run_start) begin
                last_q <= '0;
                wcnt_q <= '0;
                for (int b = 0; b < 2; b++) begin
                    beat_q[b]  <= '0;
                    waddr_q[b] <= '0;
                end
            end
            for (int b = 0; b < 2; b++) begin
                // row strobe follows the fourth beat
                we_q[b] <= hit[b] && (beat_q[b] == 2'd3);
                if (hit[b]) begin
                    beat_q[b] <= beat_q[b] + 2'd1;
                    if (rlast_i) begin
                        last_q[b] <= 1'b1;
                    end
                end
                if (we_q[b]) begin
                    waddr_q[b] <= waddr_q[b] + 1'b1;
                end
            end
            if (w_fire) begin
                wcnt_q <= wcnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run_start) begin
            addr_a_q <= mat_a_addr_i;
            addr_b_q <= mat_b_addr_i;
            addr_c_q <= mat_c_addr_i;
        end
        // first beat of a row ends up in the top lane
        for (int b = 0; b < 2; b++) begin
            if (hit[b]) begin
                pack_q[b] <= {pack_q[b][ROW_W-DATA_W-1:0], rdata_i};
            end
        end
    end

    // read address, A first then B
    assign arvalid_o = (state_q == DMA_ADDR_A) || (state_q == DMA_ADDR_B);
    assign arid_o    = (state_q == DMA_ADDR_B) ? ID_B : ID_A;
    assign araddr_o  = (state_q == DMA_ADDR_B) ? addr_b_q : addr_a_q;
    assign arlen_o   = AXI_LEN;
    assign arsize_o  = AXI_SIZE;
    assign arburst_o = AXI_INCR;
    assign rready_o  = (state_q == DMA_LOAD);

    // C write-back, row-major
    assign awvalid_o = (state_q == DMA_ADDR_C);
    assign awaddr_o  = addr_c_q;
    assign awlen_o   = AXI_LEN;
    assign awsize_o  = AXI_SIZE;
    assign awburst_o = AXI_INCR;
    assign wvalid_o  = (state_q == DMA_WRITE_C);
    assign wdata_o   = accum_i[wcnt_q];
    assign wstrb_o   = '1;
    assign wlast_o   = (state_q == DMA_WRITE_C) && (wcnt_q == BEATS - 1);
    assign bready_o  = (state_q == DMA_WAIT_B);

    assign buf_a_we_o    = we_q[0];
    assign buf_a_waddr_o = waddr_q[0];
    assign buf_a_wdata_o = pack_q[0];
    assign buf_b_we_o    = we_q[1];
    assign buf_b_waddr_o = waddr_q[1];
    assign buf_b_wdata_o = pack_q[1];

endmodule

// ==== mm_engine.sv ====
`timescale 1ns/1ps
//********************
// mm_engine
// fetches the A and B rows from the buffers and
// builds C = A x B by four outer-product steps
//********************
module mm_engine import mm_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    output logic [BUF_AW-1:0] rd_addr_o,
    input  row_t              a_row_i,
    input  row_t              b_row_i,
    output logic              done_o,
    output word_t [BEATS-1:0] accum_o
);

    mm_state_e state_q, state_d;

    // FETCH counts 0..4, MAC counts 0..3
    logic [BUF_AW:0]   cnt_q;
    logic [BUF_AW-1:0] fill_row;
    logic [BUF_AW-1:0] k;

    word_t a_mat [MAT_N][MAT_N];
    word_t b_mat [MAT_N][MAT_N];
    word_t [BEATS-1:0] acc_q;

    // read data on the bus belongs to the previous address
    assign fill_row = cnt_q[BUF_AW-1:0] - 1'b1;
    assign k        = cnt_q[BUF_AW-1:0];

    always_comb begin
        state_d = state_q;
        case (state_q)
            MM_IDLE: begin
                if (start_i) begin
                    state_d = MM_FETCH;
                end
            end
            MM_FETCH: begin
                if (cnt_q == MAT_N) begin
                    state_d = MM_MAC;
                end
            end
            MM_MAC: begin
                if (cnt_q == MAT_N - 1) begin
                    state_d = MM_FINISH;
                end
            end
            MM_FINISH: state_d = MM_IDLE;
            default:   state_d = MM_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= MM_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            case (state_q)
                MM_IDLE:  cnt_q <= '0;
                MM_FETCH: cnt_q <= (cnt_q == MAT_N) ? '0 : cnt_q + 1'b1;
                MM_MAC:   cnt_q <= cnt_q + 1'b1;
                default:  cnt_q <= '0;
            endcase
        end
    end

    // row capture
    always_ff @(posedge clk) begin
        if ((state_q == MM_FETCH) && (cnt_q != 0)) begin
            for (int j = 0; j < MAT_N; j++) begin
                a_mat[fill_row][j] <= a_row_i[ROW_W-1-j*DATA_W -: DATA_W];
                b_mat[fill_row][j] <= b_row_i[ROW_W-1-j*DATA_W -: DATA_W];
            end
        end
    end

    // column k of A times row k of B, whole array per cycle
    always_ff @(posedge clk) begin
        if ((state_q == MM_IDLE) && start_i) begin
            acc_q <= '0;
        end else if (state_q == MM_MAC) begin
            for (int i = 0; i < MAT_N; i++) begin
                for (int j = 0; j < MAT_N; j++) begin
                    acc_q[i*MAT_N+j] <= acc_q[i*MAT_N+j] + a_mat[i][k] * b_mat[k][j];
                end
            end
        end
    end

    assign rd_addr_o = cnt_q[BUF_AW-1:0];
    assign done_o    = (state_q == MM_FINISH);
    // word n is C[n/4][n%4], held until the next start
    assign accum_o   = acc_q;

endmodule

// ==== mm_top.sv ====
`timescale 1ns/1ps
//********************
// mm_top
// matrix-multiply accelerator with an AXI master port
//********************
module mm_top import mm_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  addr_t               mat_a_addr_i,
    input  addr_t               mat_b_addr_i,
    input  addr_t               mat_c_addr_i,
    input  logic                start_i,
    output logic                done_o,
    output logic                arvalid_o,
    output logic [3:0]          arid_o,
    output addr_t               araddr_o,
    output logic [7:0]          arlen_o,
    output logic [2:0]          arsize_o,
    output logic [1:0]          arburst_o,
    input  logic                arready_i,
    input  logic                rvalid_i,
    input  logic [3:0]          rid_i,
    input  word_t               rdata_i,
    input  logic                rlast_i,
    output logic                rready_o,
    output logic                awvalid_o,
    output addr_t               awaddr_o,
    output logic [7:0]          awlen_o,
    output logic [2:0]          awsize_o,
    output logic [1:0]          awburst_o,
    input  logic                awready_i,
    output logic                wvalid_o,
    output word_t               wdata_o,
    output logic [DATA_W/8-1:0] wstrb_o,
    output logic                wlast_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    input  logic [1:0]          bresp_i,
    output logic                bready_o
);

    // buffer write side
    logic              buf_a_we;
    logic              buf_b_we;
    logic [BUF_AW-1:0] buf_a_waddr;
    logic [BUF_AW-1:0] buf_b_waddr;
    row_t              buf_a_wdata;
    row_t              buf_b_wdata;

    // shared read address, both buffers
    logic [BUF_AW-1:0] rd_addr;
    row_t              buf_a_rdata;
    row_t              buf_b_rdata;

    logic              mm_start;
    logic              mm_done;
    word_t [BEATS-1:0] accum;

    dma_engine u_dma (
        .clk, .rst_n,
        .mat_a_addr_i, .mat_b_addr_i, .mat_c_addr_i, .start_i, .done_o,
        .arvalid_o, .arid_o, .araddr_o, .arlen_o, .arsize_o, .arburst_o, .arready_i,
        .rvalid_i, .rid_i, .rdata_i, .rlast_i, .rready_o,
        .awvalid_o, .awaddr_o, .awlen_o, .awsize_o, .awburst_o, .awready_i,
        .wvalid_o, .wdata_o, .wstrb_o, .wlast_o, .wready_i,
        .bvalid_i, .bresp_i, .bready_o,
        .buf_a_we_o    (buf_a_we),
        .buf_a_waddr_o (buf_a_waddr),
        .buf_a_wdata_o (buf_a_wdata),
        .buf_b_we_o    (buf_b_we),
        .buf_b_waddr_o (buf_b_waddr),
        .buf_b_wdata_o (buf_b_wdata),
        .mm_start_o    (mm_start),
        .mm_done_i     (mm_done),
        .accum_i       (accum)
    );

    mat_buffer u_buf_a (
        .clk, .we_i (buf_a_we), .waddr_i (buf_a_waddr), .wdata_i (buf_a_wdata),
        .raddr_i (rd_addr), .rdata_o (buf_a_rdata)
    );

    mat_buffer u_buf_b (
        .clk, .we_i (buf_b_we), .waddr_i (buf_b_waddr), .wdata_i (buf_b_wdata),
        .raddr_i (rd_addr), .rdata_o (buf_b_rdata)
    );

    mm_engine u_mm (
        .clk, .rst_n,
        .start_i   (mm_start),
        .rd_addr_o (rd_addr),
        .a_row_i   (buf_a_rdata),
        .b_row_i   (buf_b_rdata),
        .done_o    (mm_done),
        .accum_o   (accum)
    );

endmodule

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps
//********************
// tb_axi_mem
// AXI memory slave with random stalls, interleaved
// R ids and logs of the address requests
//********************
module tb_axi_mem import mm_pkg::*; #(
    parameter word_t SEED = 32'h2545_f491
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                arvalid_i, rready_i, awvalid_i, wvalid_i, wlast_i, bready_i,
    input  logic [3:0]          arid_i,
    input  addr_t               araddr_i, awaddr_i,
    input  logic [7:0]          arlen_i, awlen_i,
    input  logic [2:0]          arsize_i, awsize_i,
    input  logic [1:0]          arburst_i, awburst_i,
    input  word_t               wdata_i,
    input  logic [DATA_W/8-1:0] wstrb_i,
    output logic                arready_o, rvalid_o, rlast_o, awready_o, wready_o, bvalid_o,
    output logic [3:0]          rid_o,
    output word_t               rdata_o
);

    word_t mem [256];
    word_t rs = SEED;

    // open read bursts by low id bit
    logic [1:0] rd_act;
    int         rd_ptr [2];
    int         rd_left [2];
    logic       pick;
    int         w_ptr, w_len, w_idx;

    // output values for the next rising edge
    logic       arready_n, rvalid_n, rlast_n, awready_n, wready_n, bvalid_n;
    logic [3:0] rid_n;
    word_t      rdata_n;

    // request logs for the testbench
    addr_t       ar_addr_log [64];
    logic [16:0] ar_attr_log [64];
    addr_t       aw_addr_log [64];
    logic [12:0] aw_attr_log [64];
    int          ar_cnt = 0, aw_cnt = 0, w_beats = 0, w_bursts = 0, w_bad = 0;

    function automatic word_t advance_state(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5eed_0000 ^ (i * 32'h0101_0101);
        end
        {arready_n, rvalid_n, rlast_n, awready_n, wready_n, bvalid_n} = '0;
        rid_n   = '0;
        rdata_n = '0;
        rd_act  = '0;
        // outputs change only just after the rising edge
        forever begin
            {arready_o, rvalid_o, rlast_o, awready_o, wready_o, bvalid_o} =
                {arready_n, rvalid_n, rlast_n, awready_n, wready_n, bvalid_n};
            rid_o   = rid_n;
            rdata_o = rdata_n;
            @(posedge clk);
            #1;
        end
    end

    // handshakes sampled mid-cycle where both sides are stable
    always @(negedge clk) begin
        rs = advance_state(rs);
        if (!rst_n) begin
            rd_act = '0;
            {arready_n, rvalid_n, awready_n, wready_n, bvalid_n} = '0;
        end else begin
            if (arvalid_i && arready_o) begin
                ar_addr_log[ar_cnt] = araddr_i;
                ar_attr_log[ar_cnt] = {arid_i, arlen_i, arsize_i, arburst_i};
                ar_cnt++;
                rd_act[arid_i[0]]  = 1'b1;
                rd_ptr[arid_i[0]]  = araddr_i >> 2;
                rd_left[arid_i[0]] = arlen_i;
            end
            if (rvalid_o && rready_i) begin
                rvalid_n = 1'b0;
                rd_ptr[rid_o[0]]++;
                if (rlast_o) rd_act[rid_o[0]] = 1'b0;
                else rd_left[rid_o[0]]--;
            end
            // next beat from either open id with random gaps
            if (!rvalid_n && (rd_act != 2'b00) && (rs[6:5] != 2'b00)) begin
                pick     = (rd_act == 2'b11) ? rs[7] : rd_act[1];
                rvalid_n = 1'b1;
                rid_n    = {3'b000, pick};
                rdata_n  = mem[rd_ptr[pick]];
                rlast_n  = (rd_left[pick] == 0);
            end
            if (awvalid_i && awready_o) begin
                aw_addr_log[aw_cnt] = awaddr_i;
                aw_attr_log[aw_cnt] = {awlen_i, awsize_i, awburst_i};
                aw_cnt++;
                w_ptr = awaddr_i >> 2;
                w_len = awlen_i;
                w_idx = 0;
            end
            if (bvalid_o && bready_i) bvalid_n = 1'b0;
            if (wvalid_i && wready_o) begin
                mem[w_ptr + w_idx] = wdata_i;
                if ((wlast_i !== (w_idx == w_len)) || (wstrb_i !== '1)) w_bad++;
                w_beats++;
                w_idx++;
                if (wlast_i) begin
                    w_bursts++;
                    bvalid_n = 1'b1;
                end
            end
            arready_n = rs[8] | rs[9];
            awready_n = rs[10] & rs[11];
            wready_n  = rs[12] | rs[13];
        end
    end

endmodule

// ==== tb_mm_top.sv ====
`timescale 1ns/1ps
//********************
// tb_mm_top
// random matrix runs through mm_top, checked
// against a row-by-column product model
//********************
module tb_mm_top import mm_pkg::*; ();

    localparam int RUNS        = 10;
    localparam int CYCLE_LIMIT = RUNS * 300 + 100;
    localparam int SLOTS       = 16;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                start;
    addr_t               a_addr, b_addr, c_addr, araddr, awaddr;
    logic                done, arvalid, arready, rvalid, rready, rlast;
    logic                awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [3:0]          arid, rid;
    logic [7:0]          arlen, awlen;
    logic [2:0]          arsize, awsize;
    logic [1:0]          arburst, awburst;
    logic [DATA_W/8-1:0] wstrb;
    word_t               rdata, wdata;

    word_t rng = 32'd6697;
    word_t mat_a [BEATS];
    word_t mat_b [BEATS];
    word_t mat_c [BEATS];
    int    errors = 0, done_cnt = 0, cycles = 0;
    logic  b_fire = 1'b0;

    always #10 clk = ~clk;

    mm_top UUT (
        .clk, .rst_n,
        .mat_a_addr_i (a_addr), .mat_b_addr_i (b_addr), .mat_c_addr_i (c_addr),
        .start_i (start), .done_o (done),
        .arvalid_o (arvalid), .arid_o (arid), .araddr_o (araddr), .arlen_o (arlen),
        .arsize_o (arsize), .arburst_o (arburst), .arready_i (arready),
        .rvalid_i (rvalid), .rid_i (rid), .rdata_i (rdata), .rlast_i (rlast),
        .rready_o (rready),
        .awvalid_o (awvalid), .awaddr_o (awaddr), .awlen_o (awlen), .awsize_o (awsize),
        .awburst_o (awburst), .awready_i (awready),
        .wvalid_o (wvalid), .wdata_o (wdata), .wstrb_o (wstrb), .wlast_o (wlast),
        .wready_i (wready), .bvalid_i (bvalid), .bresp_i (2'b00), .bready_o (bready)
    );

    tb_axi_mem #(.SEED(32'h2545_f491)) u_mem (
        .clk, .rst_n,
        .arvalid_i (arvalid), .arid_i (arid), .araddr_i (araddr), .arlen_i (arlen),
        .arsize_i (arsize), .arburst_i (arburst), .arready_o (arready),
        .rvalid_o (rvalid), .rid_o (rid), .rdata_o (rdata), .rlast_o (rlast),
        .rready_i (rready),
        .awvalid_i (awvalid), .awaddr_i (awaddr), .awlen_i (awlen), .awsize_i (awsize),
        .awburst_i (awburst), .awready_o (awready),
        .wvalid_i (wvalid), .wdata_i (wdata), .wstrb_i (wstrb), .wlast_i (wlast),
        .wready_o (wready), .bvalid_o (bvalid), .bready_i (bready)
    );

    function automatic word_t xorshift32(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_word(input word_t exp, input word_t act, input string msg);
        if (exp !== act) begin
            errors++;
            $display("Mismatch at %0t: %s, expected %h, got %h", $time, msg, exp, act);
        end
    endtask

    task automatic check_addr(input addr_t exp, input addr_t act, input string msg);
        if (exp !== act) begin
            errors++;
            $display("Mismatch at %0t: %s, expected %h, got %h", $time, msg, exp, act);
        end
    endtask

    task automatic wait_done(input int target);
        while (done_cnt < target) @(posedge clk);
    endtask

    // done must follow each B handshake by exactly one cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (done !== b_fire) begin
                errors++;
                $display("done_o at %0t does not follow the B handshake by one cycle", $time);
            end
            if (done) done_cnt++;
        end
        b_fire = bvalid && bready;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the runs did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic do_run(input int num, input bit hold);
        int    sa, sb, sc, runs;
        int    err0, ar0, aw0, wb0, wl0, bad0, dn0;
        word_t sum;
        addr_t attr_a, attr_b, attr_w;
        // three distinct 64-byte slots for A, B and C
        rng = xorshift32(rng);
        sa  = rng % SLOTS;
        do begin
            rng = xorshift32(rng);
            sb  = rng % SLOTS;
        end while (sb == sa);
        do begin
            rng = xorshift32(rng);
            sc  = rng % SLOTS;
        end while ((sc == sa) || (sc == sb));
        for (int n = 0; n < BEATS; n++) begin
            rng      = xorshift32(rng);
            mat_a[n] = rng;
            rng      = xorshift32(rng);
            mat_b[n] = rng;
            u_mem.mem[sa*BEATS + n] = mat_a[n];
            u_mem.mem[sb*BEATS + n] = mat_b[n];
            u_mem.mem[sc*BEATS + n] = '0;
        end
        // reference product modulo 2^32
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                sum = '0;
                for (int k = 0; k < MAT_N; k++) begin
                    sum = sum + mat_a[i*MAT_N + k] * mat_b[k*MAT_N + j];
                end
                mat_c[i*MAT_N + j] = sum;
            end
        end
        err0 = errors;
        ar0  = u_mem.ar_cnt;
        aw0  = u_mem.aw_cnt;
        wb0  = u_mem.w_beats;
        wl0  = u_mem.w_bursts;
        bad0 = u_mem.w_bad;
        dn0  = done_cnt;
        @(posedge clk);
        #1;
        a_addr = sa * 64;
        b_addr = sb * 64;
        c_addr = sc * 64;
        start  = 1'b1;
        @(posedge clk);
        #1;
        if (!hold) start = 1'b0;
        runs = 1;
        wait_done(dn0 + 1);
        if (hold) begin
            // start still high so the engine leaves IDLE again on this edge
            check_word(2, u_mem.ar_cnt - ar0, "AR requests before the first done");
            for (int n = 0; n < BEATS; n++) begin
                u_mem.mem[sc*BEATS + n] = '0;
            end
            #1;
            start = 1'b0;
            runs  = 2;
            wait_done(dn0 + 2);
        end
        // id, len 15, 4-byte size, INCR
        attr_a = {4'd0, 8'd15, 3'd2, 2'd1};
        attr_b = {4'd1, 8'd15, 3'd2, 2'd1};
        attr_w = {8'd15, 3'd2, 2'd1};
        check_word(2 * runs, u_mem.ar_cnt - ar0, "AR requests");
        check_word(runs, done_cnt - dn0, "done pulses");
        check_word(runs, u_mem.aw_cnt - aw0, "AW requests");
        check_word(BEATS * runs, u_mem.w_beats - wb0, "W beats");
        check_word(runs, u_mem.w_bursts - wl0, "W bursts closed by wlast");
        check_word(0, u_mem.w_bad - bad0, "W beats with wrong wlast or wstrb");
        for (int r = 0; r < runs; r++) begin
            check_addr(sa * 64, u_mem.ar_addr_log[ar0 + 2*r], "AR address of A");
            check_addr(attr_a, u_mem.ar_attr_log[ar0 + 2*r], "AR id/len/size/burst of A");
            check_addr(sb * 64, u_mem.ar_addr_log[ar0 + 2*r + 1], "AR address of B");
            check_addr(attr_b, u_mem.ar_attr_log[ar0 + 2*r + 1], "AR id/len/size/burst of B");
            check_addr(sc * 64, u_mem.aw_addr_log[aw0 + r], "AW address");
            check_addr(attr_w, u_mem.aw_attr_log[aw0 + r], "AW len/size/burst");
        end
        for (int n = 0; n < BEATS; n++) begin
            check_word(mat_c[n], u_mem.mem[sc*BEATS + n],
                $sformatf("C[%0d][%0d] of test %0d", n / MAT_N, n % MAT_N, num));
        end
        $display("test %0d, %s: %s", num, hold ? "start held high" : "random matrices",
            (errors == err0) ? "ok" : "failed");
    endtask

    initial begin
        rst_n  = 1'b0;
        start  = 1'b0;
        a_addr = '0;
        b_addr = '0;
        c_addr = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int t = 0; t < 8; t++) begin
            do_run(t, 1'b0);
        end
        do_run(8, 1'b1);
        $display("tests 9, runs %0d, done pulses %0d, errors %0d",
            u_mem.ar_cnt / 2, done_cnt, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
mm_pkg.sv
mat_buffer.sv
dma_engine.sv
mm_engine.sv
mm_top.sv
tb_axi_mem.sv
tb_mm_top.sv
